// ==== verilog/reg_pkg.sv ====
// Register card shared definitions
// Word and byte types, register index, microcode and front-panel codes

package reg_pkg;

   ////////////////////////////////////////////////////////////
   // Data types
   ////////////////////////////////////////////////////////////

   typedef logic [15:0] word_t;              // Register or IBus value
   typedef logic [7:0]  byte_t;              // Front-panel value

   localparam int NUM_REGS    = 4;           // Major registers on the card
   localparam int PC_OUT_BITS = 6;           // Exported top of the PC

   // Register index, also the low bits of a card address
   typedef enum logic [1:0] {
      REG_PC = 2'd0,
      REG_DR = 2'd1,
      REG_AC = 2'd2,
      REG_SP = 2'd3
   } reg_id_t;

   ////////////////////////////////////////////////////////////
   // Microcode and front-panel codes
   ////////////////////////////////////////////////////////////

   // Read and write addresses owned by this card
   typedef enum logic [4:0] {
      ADDR_PC = 5'd8,
      ADDR_DR = 5'd9,
      ADDR_AC = 5'd10,
      ADDR_SP = 5'd11
   } addr_code_t;

   // Action opcodes, 0 to 7 belong to other cards
   typedef enum logic [3:0] {
      ACT_INC_PC = 4'd8,
      ACT_INC_DR = 4'd10,
      ACT_DEC_DR = 4'd11,
      ACT_INC_AC = 4'd12,
      ACT_DEC_AC = 4'd13,
      ACT_INC_SP = 4'd14,
      ACT_DEC_SP = 4'd15
   } action_t;

   // Front-panel byte select, register in bits 2:1, half in bit 0
   typedef enum logic [2:0] {
      FP_PC_LO = 3'd0,
      FP_PC_HI = 3'd1,
      FP_DR_LO = 3'd2,
      FP_DR_HI = 3'd3,
      FP_AC_LO = 3'd4,
      FP_AC_HI = 3'd5,
      FP_SP_LO = 3'd6,
      FP_SP_HI = 3'd7
   } fp_sel_t;

endpackage

// ==== verilog/ucode_decoder.sv ====
// Microcode field decoder for the register card
// Combinational decode of the read address, write address and action
// fields into per-register strobes

`timescale 1ns/1ns

module ucode_decoder (
   input  logic [4:0]                   raddr,     // IBus read address field
   input  logic [4:0]                   waddr,     // IBus write address field
   input  reg_pkg::action_t             action,    // Action opcode field
   output logic [reg_pkg::NUM_REGS-1:0] write_en,  // One-hot load from IBus
   output logic [reg_pkg::NUM_REGS-1:0] inc_en,    // One-hot increment
   output logic [reg_pkg::NUM_REGS-1:0] dec_en,    // One-hot decrement of DR, AC or SP
   output logic                         read_en,   // Card drives IBus
   output reg_pkg::reg_id_t             read_reg   // Register to drive
);
   import reg_pkg::*;

   logic    waddr_hit;                            // Write address is ours
   reg_id_t waddr_reg;                            // Register to load

   // Bit 4 low and bit 3 high mark a card address
   // Only low bits 0 to 3 are populated
   // Low bits 4 to 7 belong to other cards
   function automatic logic card_hit(input logic [4:0] addr);
      return addr inside {ADDR_PC, ADDR_DR, ADDR_AC, ADDR_SP};
   endfunction

   ////////////////////////////////////////////////////////////
   // Address decoders
   ////////////////////////////////////////////////////////////

   assign read_en   = card_hit(raddr);
   assign read_reg  = reg_id_t'(raddr[1:0]);     // Low bits index the register
   assign waddr_hit = card_hit(waddr);
   assign waddr_reg = reg_id_t'(waddr[1:0]);

   always_comb begin
      write_en = '0;
      if (waddr_hit) begin
         write_en[waddr_reg] = 1'b1;              // At most one load strobe
      end
   end

   ////////////////////////////////////////////////////////////
   // Action decoder
   ////////////////////////////////////////////////////////////

   always_comb begin
      inc_en = '0;
      dec_en = '0;
      case (action)
         ACT_INC_PC: inc_en[REG_PC] = 1'b1;      // PC only counts up
         ACT_INC_DR: inc_en[REG_DR] = 1'b1;
         ACT_DEC_DR: dec_en[REG_DR] = 1'b1;
         ACT_INC_AC: inc_en[REG_AC] = 1'b1;
         ACT_DEC_AC: dec_en[REG_AC] = 1'b1;
         ACT_INC_SP: inc_en[REG_SP] = 1'b1;      // Stack push or pop
         ACT_DEC_SP: dec_en[REG_SP] = 1'b1;
         default: ;                              // Code 9 and other cards' codes stay inert
      endcase
   end

endmodule

// ==== verilog/reg_major.sv ====
// One 16-bit major register of the card
// Loads from the IBus, or counts up or down by one with wraparound

`timescale 1ns/1ns

module reg_major (
   input  logic           clk4,     // Write phase clock
   input  logic           reset,    // Synchronous, active high
   input  reg_pkg::word_t ibus_in,  // IBus data to load
   input  logic           write,    // Load strobe
   input  logic           inc,      // Increment strobe
   input  logic           dec,      // Decrement strobe
   output reg_pkg::word_t value     // Current register contents
);
   import reg_pkg::*;

   word_t next_value;               // Value after this edge
   word_t value_inc;                // Up-count result
   word_t value_dec;                // Down-count result

   ////////////////////////////////////////////////////////////
   // Next-value logic
   ////////////////////////////////////////////////////////////

   // Both counters wrap modulo 2^16
   assign value_inc = value + 16'd1;
   assign value_dec = value - 16'd1;

   // A load wins over an action in the same cycle
   always_comb begin
      if (write) begin
         next_value = ibus_in;      // Load from bus
      end else if (inc) begin
         next_value = value_inc;    // FFFF rolls to 0000
      end else if (dec) begin
         next_value = value_dec;    // 0000 rolls to FFFF
      end else begin
         next_value = value;        // Hold
      end
   end

   ////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (reset) begin
         value <= '0;               // All majors power up at zero
      end else begin
         value <= next_value;
      end
   end

endmodule

// ==== verilog/reg_readout.sv ====
// Readout side of the register card
// IBus read multiplexer, front-panel byte multiplexer and the exported
// PC bits, accumulator and AC-zero flag

`timescale 1ns/1ns

module reg_readout (
   input  reg_pkg::word_t                  pc_value,    // Program counter
   input  reg_pkg::word_t                  dr_value,    // Data register
   input  reg_pkg::word_t                  ac_value,    // Accumulator
   input  reg_pkg::word_t                  sp_value,    // Stack pointer
   input  logic                            read_en,     // Read address is ours
   input  reg_pkg::reg_id_t                read_reg,    // Register to drive
   input  logic                            fp_en,       // Front panel enable
   input  reg_pkg::fp_sel_t                fp_sel,      // Front panel byte select
   output reg_pkg::word_t                  ibus_out,    // IBus data out
   output logic                            ibus_drive,  // IBus drive enable
   output reg_pkg::byte_t                  fpd,         // Front panel data
   output logic [reg_pkg::PC_OUT_BITS-1:0] pc_hi,       // Top of PC
   output reg_pkg::word_t                  ac,          // Exported accumulator
   output logic                            fz           // AC is zero
);
   import reg_pkg::*;

   word_t sel_word;                 // Register picked by raddr
   byte_t fp_byte;                  // Byte picked by fp_sel

   ////////////////////////////////////////////////////////////
   // IBus read path, no register delay
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (read_reg)
         REG_PC:  sel_word = pc_value;
         REG_DR:  sel_word = dr_value;
         REG_AC:  sel_word = ac_value;
         default: sel_word = sp_value;  // REG_SP
      endcase
   end

   assign ibus_out   = read_en ? sel_word : '0;  // Bus idles at zero
   assign ibus_drive = read_en;

   ////////////////////////////////////////////////////////////
   // Front panel byte select
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (fp_sel)
         FP_PC_LO: fp_byte = pc_value[7:0];
         FP_PC_HI: fp_byte = pc_value[15:8];
         FP_DR_LO: fp_byte = dr_value[7:0];
         FP_DR_HI: fp_byte = dr_value[15:8];
         FP_AC_LO: fp_byte = ac_value[7:0];
         FP_AC_HI: fp_byte = ac_value[15:8];
         FP_SP_LO: fp_byte = sp_value[7:0];
         default:  fp_byte = sp_value[15:8];   // FP_SP_HI
      endcase
   end

   assign fpd = fp_en ? fp_byte : '0;

   // Exported values and flag
   assign pc_hi = pc_value[15 -: PC_OUT_BITS];   // Bits 15:10
   assign ac    = ac_value;
   assign fz    = (ac_value == '0);

endmodule

// ==== verilog/card_reg.sv ====
// Register card top level
// Microcode decoder, the PC, DR, AC and SP major registers, and the
// bus and front-panel readout

`timescale 1ns/1ns

module card_reg (
   input  logic                            clk4,        // Write phase clock
   input  logic                            reset,       // Synchronous, active high
   input  logic [4:0]                      raddr,       // IBus read address
   input  logic [4:0]                      waddr,       // IBus write address
   input  logic [3:0]                      action,      // Action field
   input  reg_pkg::word_t                  ibus_in,     // IBus data in
   input  logic                            fp_en,       // Front panel enable
   input  reg_pkg::fp_sel_t                fp_sel,      // Front panel byte select
   output reg_pkg::word_t                  ibus_out,    // IBus data out
   output logic                            ibus_drive,  // IBus drive enable
   output reg_pkg::byte_t                  fpd,         // Front panel data
   output logic [reg_pkg::PC_OUT_BITS-1:0] pc_hi,       // PC bits 15:10
   output reg_pkg::word_t                  ac,          // Accumulator
   output logic                            fz           // AC zero flag
);
   import reg_pkg::*;

   logic [NUM_REGS-1:0] write_en;   // Per-register load strobes
   logic [NUM_REGS-1:0] inc_en;     // Per-register increment
   logic [NUM_REGS-1:0] dec_en;     // Per-register decrement
   logic                read_en;
   reg_id_t             read_reg;
   word_t               pc_value;
   word_t               dr_value;
   word_t               ac_value;
   word_t               sp_value;

   ////////////////////////////////////////////////////////////
   // Microcode decode
   ////////////////////////////////////////////////////////////

   ucode_decoder decoder_i (
      .raddr    (raddr),
      .waddr    (waddr),
      .action   (action_t'(action)),   // Raw field onto the opcode type
      .write_en (write_en),
      .inc_en   (inc_en),
      .dec_en   (dec_en),
      .read_en  (read_en),
      .read_reg (read_reg)
   );

   ////////////////////////////////////////////////////////////
   // The four major registers
   ////////////////////////////////////////////////////////////

   reg_major reg_pc_i (             // Program counter, decrement never raised
      .clk4 (clk4), .reset (reset), .ibus_in (ibus_in),
      .write (write_en[REG_PC]), .inc (inc_en[REG_PC]), .dec (dec_en[REG_PC]),
      .value (pc_value)
   );

   reg_major reg_dr_i (             // Data register
      .clk4 (clk4), .reset (reset), .ibus_in (ibus_in),
      .write (write_en[REG_DR]), .inc (inc_en[REG_DR]), .dec (dec_en[REG_DR]),
      .value (dr_value)
   );

   reg_major reg_ac_i (             // Accumulator
      .clk4 (clk4), .reset (reset), .ibus_in (ibus_in),
      .write (write_en[REG_AC]), .inc (inc_en[REG_AC]), .dec (dec_en[REG_AC]),
      .value (ac_value)
   );

   reg_major reg_sp_i (             // Stack pointer
      .clk4 (clk4), .reset (reset), .ibus_in (ibus_in),
      .write (write_en[REG_SP]), .inc (inc_en[REG_SP]), .dec (dec_en[REG_SP]),
      .value (sp_value)
   );

   ////////////////////////////////////////////////////////////
   // Bus, front panel and exported outputs
   ////////////////////////////////////////////////////////////

   reg_readout readout_i (
      .pc_value   (pc_value),
      .dr_value   (dr_value),
      .ac_value   (ac_value),
      .sp_value   (sp_value),
      .read_en    (read_en),
      .read_reg   (read_reg),
      .fp_en      (fp_en),
      .fp_sel     (fp_sel),
      .ibus_out   (ibus_out),
      .ibus_drive (ibus_drive),
      .fpd        (fpd),
      .pc_hi      (pc_hi),
      .ac         (ac),
      .fz         (fz)
   );

endmodule

// ==== verif/card_reg_asserts.sv ====
// Register card assertions
// Bus drive ownership, the AC-zero flag and clearing by reset

`timescale 1ns/1ns

module card_reg_asserts (
   input logic           clk4,
   input logic           reset,
   input logic [4:0]     raddr,
   input logic           ibus_drive,
   input logic           fz,
   input reg_pkg::word_t ac,
   input reg_pkg::word_t pc_value,
   input reg_pkg::word_t dr_value,
   input reg_pkg::word_t ac_value,
   input reg_pkg::word_t sp_value
);
   import reg_pkg::*;

   // Only codes 8 to 11 may drive the bus
   drive_owner_a: assert property (@(posedge clk4)
      ibus_drive |-> raddr inside {[5'd8:5'd11]})
      else $error("ibus_drive high for a foreign read address");

   ac_zero_flag_a: assert property (@(posedge clk4) disable iff (reset)
      fz == (ac == 16'd0))
      else $error("fz does not match the accumulator");

   // Every reset cycle leaves all four registers clear
   reset_clear_a: assert property (@(posedge clk4)
      reset |=> (pc_value == 16'd0 && dr_value == 16'd0 &&
                 ac_value == 16'd0 && sp_value == 16'd0))
      else $error("register not zero after a reset cycle");

endmodule

bind card_reg card_reg_asserts asserts_i (
   .clk4 (clk4), .reset (reset), .raddr (raddr),
   .ibus_drive (ibus_drive), .fz (fz), .ac (ac),
   .pc_value (pc_value), .dr_value (dr_value),
   .ac_value (ac_value), .sp_value (sp_value)
);

// ==== verif/card_reg_tb.sv ====
// Register card testbench
// Directed and random microcode fields, with every output checked against
// a reference model of the four registers just before each rising edge

`timescale 1ns/1ns

module card_reg_tb;
   import reg_pkg::*;

   typedef logic [NUM_REGS-1:0][15:0] regset_t;    // Indexed by reg_id_t
   typedef struct packed {
      logic  drive;
      word_t bus;
      byte_t fpd;
   } bus_exp_t;

   logic                   clk4;
   logic                   reset;
   logic [4:0]             raddr;
   logic [4:0]             waddr;
   logic [3:0]             action;
   word_t                  ibus_in;
   logic                   fp_en;
   fp_sel_t                fp_sel;
   word_t                  ibus_out;
   logic                   ibus_drive;
   byte_t                  fpd;
   logic [PC_OUT_BITS-1:0] pc_hi;
   word_t                  ac;
   logic                   fz;
   regset_t                model;             // Expected PC, DR, AC, SP
   bus_exp_t               exp_o;             // Expected bus and panel
   logic [31:0]            rng;               // Xorshift state
   logic                   checking;          // Off until reset is released
   int                     checks;            // Compared cycles
   int                     target;

   always #50 clk4 = ~clk4;                   // 100 ns period

   card_reg dut_i (.*);

   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk4);            // 16 reset cycles
      #10;
      reset = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // Action 8 counts the PC, 10 to 15 pick a register by bits 2:1
   // A load from the bus overrides the action
   function automatic regset_t next_regs(input regset_t cur, input logic [4:0] wa,
                                         input logic [3:0] act, input word_t data);
      regset_t    nxt;
      logic [1:0] idx;
      nxt = cur;
      idx = act[2:1];
      if (act[3] && act != 4'd9) begin
         nxt[idx] = act[0] ? cur[idx] - 16'd1 : cur[idx] + 16'd1;  // Wraps at 16 bits
      end
      if (wa[4:2] == 3'b010) begin            // Card address, low bits 0 to 3
         nxt[wa[1:0]] = data;
      end
      return nxt;
   endfunction

   // Expected bus and front panel outputs for the current register values
   function automatic bus_exp_t expected_out(input regset_t r, input logic [4:0] ra,
                                             input logic en, input logic [2:0] sel);
      bus_exp_t e;
      word_t    w;
      e = '0;
      w = r[sel[2:1]];                        // Register in bits 2:1
      if (ra[4:2] == 3'b010) begin
         e.drive = 1'b1;
         e.bus   = r[ra[1:0]];
      end
      if (en) begin
         e.fpd = sel[0] ? w[15:8] : w[7:0];   // High byte on odd codes
      end
      return e;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t got);
      if (got !== exp) begin
         report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, got));
      end
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t got);
      if (got !== exp) begin
         report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, got));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, got));
      end
   endtask

   task automatic check_pc_bits(input string name, input logic [PC_OUT_BITS-1:0] exp,
                                input logic [PC_OUT_BITS-1:0] got);
      if (got !== exp) begin
         report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, got));
      end
   endtask

   // Compare just before each edge, then move the model across it
   always begin
      @(posedge clk4);
      #90;
      if (checking) begin
         exp_o = expected_out(model, raddr, fp_en, fp_sel);
         check_bit("ibus_drive", exp_o.drive, ibus_drive);
         check_word("ibus_out", exp_o.bus, ibus_out);
         check_byte("fpd", exp_o.fpd, fpd);
         check_pc_bits("pc_hi", model[REG_PC][15:10], pc_hi);
         check_word("ac", model[REG_AC], ac);
         check_bit("fz", model[REG_AC] == 16'd0, fz);
         checks++;
      end
      model = reset ? '0 : next_regs(model, waddr, action, ibus_in);
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   task automatic drive(input logic [4:0] ra, input logic [4:0] wa,
                        input logic [3:0] act, input word_t data);
      @(posedge clk4);
      #10;                                    // Clear of the edge
      raddr   = ra;
      waddr   = wa;
      action  = act;
      ibus_in = data;
   endtask

   task automatic expect_read(input logic [4:0] ra, input word_t value);
      drive(ra, 5'd0, 4'd0, 16'h0000);
      #75;
      check_word("ibus_out", value, ibus_out);
   endtask

   initial begin
      clk4     = 1'b0;
      model    = '0;
      rng      = 32'd26;                      // Seed
      checking = 1'b0;
      checks   = 0;
      raddr    = 5'd0;                        // Foreign code during reset
      waddr    = 5'd0;
      action   = 4'd0;
      ibus_in  = '0;
      fp_en    = 1'b1;
      fp_sel   = FP_PC_LO;
      for (int n = 0; n < 40 && reset !== 1'b0; n++) begin
         @(posedge clk4);
      end
      if (reset !== 1'b0) begin
         report_failure("Reset was not released in time");
      end
      checking = 1'b1;
      for (int i = 0; i < NUM_REGS; i++) begin
         expect_read({3'b010, i[1:0]}, 16'h0000);   // All clear after reset
      end
      drive(5'd0, ADDR_PC, 4'd0, 16'hfc12);
      drive(5'd0, ADDR_DR, 4'd0, 16'h1234);
      drive(5'd0, ADDR_AC, 4'd0, 16'hbeef);
      drive(5'd0, ADDR_SP, 4'd0, 16'h0ffe);
      expect_read(ADDR_PC, 16'hfc12);
      expect_read(ADDR_DR, 16'h1234);
      expect_read(ADDR_AC, 16'hbeef);
      expect_read(ADDR_SP, 16'h0ffe);
      for (int a = 0; a < 32; a++) begin
         drive(a[4:0], 5'd0, 4'd0, 16'h0000);        // Other cards leave the bus idle
      end
      drive(5'd0, ADDR_DR, 4'd0, 16'hffff);
      drive(ADDR_DR, ADDR_AC, ACT_INC_DR, 16'h0000); // DR wraps to 0000
      drive(ADDR_AC, 5'd0, ACT_DEC_DR, 16'h0000);    // And back
      drive(ADDR_AC, 5'd0, ACT_DEC_AC, 16'h0000);    // AC wraps to FFFF
      drive(5'd0, ADDR_SP, ACT_INC_AC, 16'hffff);
      drive(5'd0, 5'd0, ACT_INC_SP, 16'h0000);       // SP wraps to 0000
      drive(5'd0, 5'd0, ACT_DEC_SP, 16'h0000);
      repeat (3) drive(5'd0, 5'd0, ACT_INC_PC, 16'h0000);
      expect_read(ADDR_DR, 16'hffff);
      expect_read(ADDR_AC, 16'h0000);
      expect_read(ADDR_SP, 16'hffff);
      expect_read(ADDR_PC, 16'hfc15);
      for (int a = 0; a < 9; a++) begin
         drive(ADDR_PC, 5'd0, (a == 8) ? 4'd9 : a[3:0], 16'h0000);  // Inert codes
      end
      expect_read(ADDR_PC, 16'hfc15);
      drive(5'd0, ADDR_AC, ACT_INC_AC, 16'h5a5a);    // Load beats increment
      drive(ADDR_SP, ADDR_SP, 4'd0, 16'h7777);       // Same-cycle read sees old SP
      #75;
      check_word("ibus_out", 16'hffff, ibus_out);
      expect_read(ADDR_AC, 16'h5a5a);
      expect_read(ADDR_SP, 16'h7777);
      for (int s = 0; s < 16; s++) begin
         drive(5'd0, 5'd0, 4'd0, 16'h0000);
         fp_en  = (s < 8);                           // Panel on for the first pass
         fp_sel = fp_sel_t'(s[2:0]);
      end
      for (int n = 0; n < 400; n++) begin
         rng = xorshift(rng);
         drive(rng[18] ? rng[4:0] : {3'b010, rng[1:0]},   // Bias toward card codes
               rng[19] ? rng[9:5] : {3'b010, rng[6:5]}, rng[13:10], rng[31:16]);
         fp_en  = rng[14];
         fp_sel = fp_sel_t'(rng[17:15]);
      end
      target = checks + 2;
      for (int n = 0; n < 10 && checks < target; n++) begin
         @(posedge clk4);
      end
      if (checks >= target) begin
         $display("Test OK");
         $finish;
      end else begin
         report_failure("Compare process stopped before the end of the run");
      end
   end

endmodule

// ==== compile.f ====
verilog/reg_pkg.sv
verilog/ucode_decoder.sv
verilog/reg_major.sv
verilog/reg_readout.sv
verilog/card_reg.sv
verif/card_reg_asserts.sv
verif/card_reg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the register card testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module card_reg_tb -f compile.f; then
   echo "Verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/Vcard_reg_tb 2>&1)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
   exit 0
fi
exit 1
